// File: exec_pkg.sv
package exec_pkg;

    // data path
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;       // operands, results, next-pc

    // reorder buffer
    localparam int ROB_LEN = 32;
    typedef logic [$clog2(ROB_LEN)-1:0] rob_tag_t;  // 5 bit rob tag

    // unit counts, one alu and one mult per lane
    localparam int NUM_LANES   = 3;
    localparam int NUM_FU_ALU  = 3;
    localparam int NUM_FU_MULT = 3;

    // cdb ports per cycle
    localparam int CDB_WIDTH = 3;

    // mults own slots 0..2, alus own 3..5
    localparam int COMP_SLOTS = NUM_FU_MULT + NUM_FU_ALU;

    // multiplier depth and the slice of opb folded in per stage
    localparam int MULT_STAGES = 4;
    localparam int MULT_CHUNK  = XLEN / MULT_STAGES;

    // which unit a lane instruction goes to
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_kind_e;

    // alu functions, mult ignores this
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLTU = 3'd5
    } alu_func_e;

endpackage

// File: fu_if.sv
`timescale 1ns/1ps

// issue path, router to one unit
// transfer on an edge with valid and ready both high
interface fu_issue_if import exec_pkg::*; ();
    logic      valid;
    rob_tag_t  tag;
    alu_func_e func;
    word_t     opa;
    word_t     opb;
    word_t     npc;
    logic      halt;
    logic      ready;   // unit can take an op this cycle

    modport router (output valid, tag, func, opa, opb, npc, halt, input ready);
    modport unit   (input valid, tag, func, opa, opb, npc, halt, output ready);
endinterface

// result path, unit to its completion slot
// unit holds everything steady until accept
interface fu_result_if import exec_pkg::*; ();
    logic     valid;
    rob_tag_t tag;
    word_t    value;
    word_t    npc;
    logic     halt;
    logic     accept;   // slot was empty at start of cycle

    modport unit   (output valid, tag, value, npc, halt, input accept);
    modport buffer (input valid, tag, value, npc, halt, output accept);
endinterface

// File: issue_router.sv
`timescale 1ns/1ps

module issue_router import exec_pkg::*; (
    input  logic      [NUM_LANES-1:0] issue_valid_i,
    input  fu_kind_e  [NUM_LANES-1:0] issue_unit_i,
    input  alu_func_e [NUM_LANES-1:0] issue_func_i,
    input  rob_tag_t  [NUM_LANES-1:0] issue_tag_i,
    input  word_t     [NUM_LANES-1:0] issue_opa_i,
    input  word_t     [NUM_LANES-1:0] issue_opb_i,
    input  word_t     [NUM_LANES-1:0] issue_npc_i,
    input  logic      [NUM_LANES-1:0] issue_halt_i,
    output logic      [NUM_LANES-1:0] issue_ready_o,
    fu_issue_if.router                alu_issue  [NUM_FU_ALU],
    fu_issue_if.router                mult_issue [NUM_FU_MULT]
);

    // lane g feeds alu g and mult g, no crossbar
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        // only the named unit sees valid
        assign alu_issue[g].valid  = issue_valid_i[g] && (issue_unit_i[g] == FU_ALU);
        assign mult_issue[g].valid = issue_valid_i[g] && (issue_unit_i[g] == FU_MULT);

        // payload goes to both, cheaper than muxing
        assign alu_issue[g].tag  = issue_tag_i[g];
        assign alu_issue[g].func = issue_func_i[g];
        assign alu_issue[g].opa  = issue_opa_i[g];
        assign alu_issue[g].opb  = issue_opb_i[g];
        assign alu_issue[g].npc  = issue_npc_i[g];
        assign alu_issue[g].halt = issue_halt_i[g];

        assign mult_issue[g].tag  = issue_tag_i[g];
        assign mult_issue[g].func = issue_func_i[g];   // unused by the mult
        assign mult_issue[g].opa  = issue_opa_i[g];
        assign mult_issue[g].opb  = issue_opb_i[g];
        assign mult_issue[g].npc  = issue_npc_i[g];
        assign mult_issue[g].halt = issue_halt_i[g];

        // back-pressure from whichever unit the lane names
        // combinational on issue_unit_i, valid not needed
        assign issue_ready_o[g] = (issue_unit_i[g] == FU_ALU) ? alu_issue[g].ready
                                                              : mult_issue[g].ready;
    end

endmodule

// File: fu_alu.sv
`timescale 1ns/1ps

module fu_alu import exec_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       clear_i,
    fu_issue_if.unit   issue,
    fu_result_if.unit  result
);

    logic     out_valid;    // output reg holds a result
    rob_tag_t out_tag;
    word_t    out_value;
    word_t    out_npc;
    logic     out_halt;
    word_t    alu_value;    // combinational result of the issued op
    logic     issue_fire;

    // free slot, or the held result leaves this cycle
    assign issue.ready = !out_valid || result.accept;
    assign issue_fire  = issue.valid && issue.ready;

    always_comb begin
        case (issue.func)
            ALU_ADD:  alu_value = issue.opa + issue.opb;
            ALU_SUB:  alu_value = issue.opa - issue.opb;
            ALU_AND:  alu_value = issue.opa & issue.opb;
            ALU_OR:   alu_value = issue.opa | issue.opb;
            ALU_XOR:  alu_value = issue.opa ^ issue.opb;
            ALU_SLTU: alu_value = word_t'(issue.opa < issue.opb);  // 1 or 0
            default:  alu_value = '0;
        endcase
    end

    // occupancy of the output reg
    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            out_valid <= 1'b0;              // squash drops the held result
        end else if (issue_fire) begin
            out_valid <= 1'b1;              // refill, may overlap a drain
        end else if (result.accept) begin
            out_valid <= 1'b0;              // handed to the buffer
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            out_tag   <= issue.tag;
            out_value <= alu_value;
            out_npc   <= issue.npc;
            out_halt  <= issue.halt;
        end
    end

    assign result.valid = out_valid;
    assign result.tag   = out_tag;
    assign result.value = out_value;
    assign result.npc   = out_npc;
    assign result.halt  = out_halt;

endmodule

// File: fu_mult.sv
`timescale 1ns/1ps

module fu_mult import exec_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       clear_i,
    fu_issue_if.unit   issue,
    fu_result_if.unit  result
);

    logic [MULT_STAGES-1:0] st_valid;       // bit k = stage k full
    rob_tag_t               st_tag [MULT_STAGES];
    word_t                  st_npc [MULT_STAGES];
    logic                   st_halt [MULT_STAGES];
    word_t                  st_acc [MULT_STAGES];     // partial product so far
    // operands only travel as far as the stage that still needs them
    word_t                  st_opa [MULT_STAGES-1];
    word_t                  st_opb [MULT_STAGES-1];
    word_t                  part [MULT_STAGES];       // next acc per stage
    logic                   advance;

    // whole pipe moves when the last stage is empty or draining
    assign advance     = !st_valid[MULT_STAGES-1] || result.accept;
    assign issue.ready = advance;

    // stage k folds in opb slice k, low XLEN bits only
    always_comb begin
        part[0] = issue.opa * word_t'(issue.opb[MULT_CHUNK-1:0]);
        for (int k = 1; k < MULT_STAGES; k++) begin
            part[k] = st_acc[k-1]
                    + ((st_opa[k-1] * word_t'(st_opb[k-1][k*MULT_CHUNK +: MULT_CHUNK]))
                       << (k * MULT_CHUNK));
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            st_valid <= '0;                 // flush everything in flight
        end else if (advance) begin
            // issue.valid is a fire here since ready == advance
            st_valid <= {st_valid[MULT_STAGES-2:0], issue.valid};
        end
    end

    // payload shifts with the valids, no reset needed
    always_ff @(posedge clock) begin
        if (advance) begin
            st_tag[0]  <= issue.tag;
            st_npc[0]  <= issue.npc;
            st_halt[0] <= issue.halt;
            st_acc[0]  <= part[0];
            st_opa[0]  <= issue.opa;
            st_opb[0]  <= issue.opb;
            for (int k = 1; k < MULT_STAGES; k++) begin
                st_tag[k]  <= st_tag[k-1];
                st_npc[k]  <= st_npc[k-1];
                st_halt[k] <= st_halt[k-1];
                st_acc[k]  <= part[k];
            end
            for (int k = 1; k < MULT_STAGES - 1; k++) begin
                st_opa[k] <= st_opa[k-1];
                st_opb[k] <= st_opb[k-1];
            end
        end
    end

    // last stage is the held result
    assign result.valid = st_valid[MULT_STAGES-1];
    assign result.tag   = st_tag[MULT_STAGES-1];
    assign result.value = st_acc[MULT_STAGES-1];
    assign result.npc   = st_npc[MULT_STAGES-1];
    assign result.halt  = st_halt[MULT_STAGES-1];

endmodule

// File: complete_buffer.sv
`timescale 1ns/1ps

module complete_buffer import exec_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       clear_i,
    fu_result_if.buffer                mult_res [NUM_FU_MULT],
    fu_result_if.buffer                alu_res  [NUM_FU_ALU],
    output logic     [CDB_WIDTH-1:0]   cdb_valid_o,
    output rob_tag_t [CDB_WIDTH-1:0]   cdb_tag_o,
    output word_t    [CDB_WIDTH-1:0]   cdb_value_o,
    output word_t    [CDB_WIDTH-1:0]   cdb_npc_o,
    output logic     [CDB_WIDTH-1:0]   cdb_halt_o
);

    // flattened view of the unit outputs, slot order
    logic     [COMP_SLOTS-1:0] res_valid;
    rob_tag_t                  res_tag [COMP_SLOTS];
    word_t                     res_value [COMP_SLOTS];
    word_t                     res_npc [COMP_SLOTS];
    logic                      res_halt [COMP_SLOTS];

    // slot table and its next state
    logic     [COMP_SLOTS-1:0] slot_valid, nxt_valid;
    rob_tag_t                  slot_tag [COMP_SLOTS], nxt_tag [COMP_SLOTS];
    word_t                     slot_value [COMP_SLOTS], nxt_value [COMP_SLOTS];
    word_t                     slot_npc [COMP_SLOTS], nxt_npc [COMP_SLOTS];
    logic                      slot_halt [COMP_SLOTS], nxt_halt [COMP_SLOTS];

    // next cdb contents
    logic     [CDB_WIDTH-1:0]  cdb_valid_n;
    rob_tag_t [CDB_WIDTH-1:0]  cdb_tag_n;
    word_t    [CDB_WIDTH-1:0]  cdb_value_n;
    word_t    [CDB_WIDTH-1:0]  cdb_npc_n;
    logic     [CDB_WIDTH-1:0]  cdb_halt_n;

    for (genvar g = 0; g < NUM_FU_MULT; g++) begin : g_mult
        assign res_valid[g]      = mult_res[g].valid;
        assign res_tag[g]        = mult_res[g].tag;
        assign res_value[g]      = mult_res[g].value;
        assign res_npc[g]        = mult_res[g].npc;
        assign res_halt[g]       = mult_res[g].halt;
        assign mult_res[g].accept = !slot_valid[g];     // registered state only
    end

    for (genvar g = 0; g < NUM_FU_ALU; g++) begin : g_alu
        assign res_valid[NUM_FU_MULT+g] = alu_res[g].valid;
        assign res_tag[NUM_FU_MULT+g]   = alu_res[g].tag;
        assign res_value[NUM_FU_MULT+g] = alu_res[g].value;
        assign res_npc[NUM_FU_MULT+g]   = alu_res[g].npc;
        assign res_halt[NUM_FU_MULT+g]  = alu_res[g].halt;
        assign alu_res[g].accept        = !slot_valid[NUM_FU_MULT+g];
    end

    always_comb begin : pick
        int n;
        nxt_valid = slot_valid;
        nxt_tag   = slot_tag;
        nxt_value = slot_value;
        nxt_npc   = slot_npc;
        nxt_halt  = slot_halt;
        // take new results into empty slots first
        for (int s = 0; s < COMP_SLOTS; s++) begin
            if (res_valid[s] && !slot_valid[s]) begin
                nxt_valid[s] = 1'b1;
                nxt_tag[s]   = res_tag[s];
                nxt_value[s] = res_value[s];
                nxt_npc[s]   = res_npc[s];
                nxt_halt[s]  = res_halt[s];
            end
        end
        cdb_valid_n = '0;
        cdb_tag_n   = '0;
        cdb_value_n = '0;
        cdb_npc_n   = '0;
        cdb_halt_n  = '0;
        n = 0;
        // lowest slot first, ports fill from 0 up
        for (int s = 0; s < COMP_SLOTS; s++) begin
            if (nxt_valid[s] && n < CDB_WIDTH) begin
                cdb_valid_n[n] = 1'b1;
                cdb_tag_n[n]   = nxt_tag[s];
                cdb_value_n[n] = nxt_value[s];
                cdb_npc_n[n]   = nxt_npc[s];
                cdb_halt_n[n]  = nxt_halt[s];
                nxt_valid[s]   = 1'b0;      // freed on the same edge
                n = n + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            slot_valid  <= '0;
            cdb_valid_o <= '0;              // squash also kills the bus
        end else begin
            slot_valid  <= nxt_valid;
            cdb_valid_o <= cdb_valid_n;
        end
    end

    always_ff @(posedge clock) begin
        slot_tag    <= nxt_tag;
        slot_value  <= nxt_value;
        slot_npc    <= nxt_npc;
        slot_halt   <= nxt_halt;
        cdb_tag_o   <= cdb_tag_n;
        cdb_value_o <= cdb_value_n;
        cdb_npc_o   <= cdb_npc_n;
        cdb_halt_o  <= cdb_halt_n;
    end

endmodule

// File: exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       clear_i,       // squash
    // issue lanes
    input  logic      [NUM_LANES-1:0]  issue_valid_i,
    input  fu_kind_e  [NUM_LANES-1:0]  issue_unit_i,
    input  alu_func_e [NUM_LANES-1:0]  issue_func_i,
    input  rob_tag_t  [NUM_LANES-1:0]  issue_tag_i,
    input  word_t     [NUM_LANES-1:0]  issue_opa_i,
    input  word_t     [NUM_LANES-1:0]  issue_opb_i,
    input  word_t     [NUM_LANES-1:0]  issue_npc_i,
    input  logic      [NUM_LANES-1:0]  issue_halt_i,
    output logic      [NUM_LANES-1:0]  issue_ready_o,
    // cdb, registered
    output logic      [CDB_WIDTH-1:0]  cdb_valid_o,
    output rob_tag_t  [CDB_WIDTH-1:0]  cdb_tag_o,
    output word_t     [CDB_WIDTH-1:0]  cdb_value_o,
    output word_t     [CDB_WIDTH-1:0]  cdb_npc_o,
    output logic      [CDB_WIDTH-1:0]  cdb_halt_o
);

    fu_issue_if  alu_issue  [NUM_FU_ALU] ();
    fu_issue_if  mult_issue [NUM_FU_MULT] ();
    fu_result_if alu_res    [NUM_FU_ALU] ();
    fu_result_if mult_res   [NUM_FU_MULT] ();

    issue_router u_router (
        .issue_valid_i (issue_valid_i),
        .issue_unit_i  (issue_unit_i),
        .issue_func_i  (issue_func_i),
        .issue_tag_i   (issue_tag_i),
        .issue_opa_i   (issue_opa_i),
        .issue_opb_i   (issue_opb_i),
        .issue_npc_i   (issue_npc_i),
        .issue_halt_i  (issue_halt_i),
        .issue_ready_o (issue_ready_o),
        .alu_issue     (alu_issue),
        .mult_issue    (mult_issue)
    );

    // single cycle alus
    for (genvar g = 0; g < NUM_FU_ALU; g++) begin : g_alu
        fu_alu u_alu (
            .clock   (clock),
            .reset   (reset),
            .clear_i (clear_i),
            .issue   (alu_issue[g]),
            .result  (alu_res[g])
        );
    end

    // pipelined multipliers
    for (genvar g = 0; g < NUM_FU_MULT; g++) begin : g_mult
        fu_mult u_mult (
            .clock   (clock),
            .reset   (reset),
            .clear_i (clear_i),
            .issue   (mult_issue[g]),
            .result  (mult_res[g])
        );
    end

    complete_buffer u_cbuf (
        .clock       (clock),
        .reset       (reset),
        .clear_i     (clear_i),
        .mult_res    (mult_res),
        .alu_res     (alu_res),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag_o),
        .cdb_value_o (cdb_value_o),
        .cdb_npc_o   (cdb_npc_o),
        .cdb_halt_o  (cdb_halt_o)
    );

endmodule

// File: exec_checker.sv
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      clear_i,
    input  logic      [NUM_LANES-1:0] issue_valid_i,
    input  fu_kind_e  [NUM_LANES-1:0] issue_unit_i,
    input  alu_func_e [NUM_LANES-1:0] issue_func_i,
    input  rob_tag_t  [NUM_LANES-1:0] issue_tag_i,
    input  word_t     [NUM_LANES-1:0] issue_opa_i,
    input  word_t     [NUM_LANES-1:0] issue_opb_i,
    input  word_t     [NUM_LANES-1:0] issue_npc_i,
    input  logic      [NUM_LANES-1:0] issue_halt_i,
    input  logic      [NUM_LANES-1:0] issue_ready_i,
    input  logic      [CDB_WIDTH-1:0] cdb_valid_i,
    input  rob_tag_t  [CDB_WIDTH-1:0] cdb_tag_i,
    input  word_t     [CDB_WIDTH-1:0] cdb_value_i,
    input  word_t     [CDB_WIDTH-1:0] cdb_npc_i,
    input  logic      [CDB_WIDTH-1:0] cdb_halt_i,
    input  logic                      done_i,       // run over, report leftovers
    output int                        pending_o,
    output int                        value_errs_o,
    output int                        proto_errs_o,
    output int                        lost_errs_o
);

    logic [ROB_LEN-1:0] busy;                 // tag accepted, not yet broadcast
    fu_kind_e           exp_kind  [ROB_LEN];
    word_t              exp_value [ROB_LEN];
    word_t              exp_npc   [ROB_LEN];
    logic               exp_halt  [ROB_LEN];
    int                 acc_edge  [ROB_LEN];  // edge the op was taken on
    int                 edge_cnt  = 0;
    int                 n_pending = 0;
    int                 n_value   = 0;
    int                 n_proto   = 0;
    int                 n_lost    = 0;
    logic               leftovers_done = 1'b0;

    assign pending_o    = n_pending;
    assign value_errs_o = n_value;
    assign proto_errs_o = n_proto;
    assign lost_errs_o  = n_lost;

    always @(posedge clock) edge_cnt <= edge_cnt + 1;

    function automatic word_t alu_model(alu_func_e f, word_t a, word_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLTU: return (a < b) ? word_t'(1) : word_t'(0);
            default:  return '0;
        endcase
    endfunction

    // full product, keep the low word
    function automatic word_t mult_model(word_t a, word_t b);
        logic [2*XLEN-1:0] p;
        p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        return p[XLEN-1:0];
    endfunction

    task automatic record_issue(input int l);
        rob_tag_t t;
        t = issue_tag_i[l];
        if (busy[t]) begin
            $display("lane %0d issued tag %0d while it was still outstanding", l, t);
            n_proto++;
        end else begin
            n_pending++;
        end
        busy[t]      = 1'b1;
        exp_kind[t]  = issue_unit_i[l];
        exp_value[t] = (issue_unit_i[l] == FU_MULT)
                     ? mult_model(issue_opa_i[l], issue_opb_i[l])
                     : alu_model(issue_func_i[l], issue_opa_i[l], issue_opb_i[l]);
        exp_npc[t]   = issue_npc_i[l];
        exp_halt[t]  = issue_halt_i[l];
        acc_edge[t]  = edge_cnt + 1;          // taken on the coming edge
    endtask

    task automatic check_port(input int p);
        rob_tag_t t;
        int       lat;
        int       need;
        t = cdb_tag_i[p];
        if (!busy[t]) begin
            $display("cdb port %0d broadcast tag %0d, which is not outstanding", p, t);
            n_proto++;
            return;
        end
        lat  = edge_cnt - acc_edge[t] + 1;    // issue edge counts as the first
        need = (exp_kind[t] == FU_MULT) ? MULT_STAGES + 1 : 2;
        if (lat < need) begin
            $display("tag %0d arrived after %0d edges, minimum is %0d", t, lat, need);
            n_proto++;
        end
        if (cdb_value_i[p] !== exp_value[t]) begin
            $display("** Error: cdb_value_o[%0d] tag %h: got %h, expected %h",
                     p, t, cdb_value_i[p], exp_value[t]);
            n_value++;
        end
        if (cdb_npc_i[p] !== exp_npc[t]) begin
            $display("** Error: cdb_npc_o[%0d] tag %h: got %h, expected %h",
                     p, t, cdb_npc_i[p], exp_npc[t]);
            n_value++;
        end
        if (cdb_halt_i[p] !== exp_halt[t]) begin
            $display("** Error: cdb_halt_o[%0d] tag %h: got %h, expected %h",
                     p, t, cdb_halt_i[p], exp_halt[t]);
            n_value++;
        end
        busy[t] = 1'b0;
        n_pending--;
    endtask

    // negedge sampling, everything settled since the last rising edge
    always @(negedge clock) begin : sample
        logic gap;
        if (reset) begin
            busy      = '0;
            n_pending = 0;
        end else begin
            gap = 1'b0;
            for (int p = 0; p < CDB_WIDTH; p++) begin
                if (!cdb_valid_i[p]) begin
                    gap = 1'b1;
                end else begin
                    if (gap) begin
                        $display("cdb port %0d is valid above an empty lower port", p);
                        n_proto++;
                    end
                    check_port(p);
                end
            end
            // nothing outstanding means every unit is empty
            if (n_pending == 0 && issue_ready_i !== '1) begin
                $display("** Error: issue_ready_o: got %h, expected %h", issue_ready_i,
                         {NUM_LANES{1'b1}});
                n_value++;
            end
            if (clear_i) begin
                busy      = '0;               // squash drops every record
                n_pending = 0;
            end else begin
                for (int l = 0; l < NUM_LANES; l++)
                    if (issue_valid_i[l] && issue_ready_i[l]) record_issue(l);
            end
            if (done_i && !leftovers_done) begin
                for (int t = 0; t < ROB_LEN; t++) begin
                    if (busy[t]) begin
                        $display("tag %0d was accepted but never broadcast", t);
                        n_lost++;
                    end
                end
                leftovers_done = 1'b1;
            end
        end
    end

endmodule

// File: tb_exec.sv
`timescale 1ns/1ps

module tb_exec import exec_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int RAND_CYCLES  = 3000;   // random mix with squashes
    localparam int PRESS_CYCLES = 1500;   // lanes offer nearly every cycle
    localparam int DRAIN_CYCLES = 100;    // upper bound on the final drain
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RAND_CYCLES + PRESS_CYCLES + 200;

    logic                      clock   = 1'b0;
    logic                      reset   = 1'b1;
    logic                      clear_i = 1'b0;
    logic      [NUM_LANES-1:0] issue_valid_i = '0;
    fu_kind_e  [NUM_LANES-1:0] issue_unit_i  = {NUM_LANES{FU_ALU}};
    alu_func_e [NUM_LANES-1:0] issue_func_i  = {NUM_LANES{ALU_ADD}};
    rob_tag_t  [NUM_LANES-1:0] issue_tag_i   = '0;
    word_t     [NUM_LANES-1:0] issue_opa_i   = '0;
    word_t     [NUM_LANES-1:0] issue_opb_i   = '0;
    word_t     [NUM_LANES-1:0] issue_npc_i   = '0;
    logic      [NUM_LANES-1:0] issue_halt_i  = '0;
    logic      [NUM_LANES-1:0] issue_ready_o;
    logic      [CDB_WIDTH-1:0] cdb_valid_o;
    rob_tag_t  [CDB_WIDTH-1:0] cdb_tag_o;
    word_t     [CDB_WIDTH-1:0] cdb_value_o;
    word_t     [CDB_WIDTH-1:0] cdb_npc_o;
    logic      [CDB_WIDTH-1:0] cdb_halt_o;

    int                 phase = 0;        // 0 idle, 1 random, 2 pressure, 3 drain
    logic               run_done = 1'b0;
    logic [31:0]        rng_state = 32'd54840;
    logic [ROB_LEN-1:0] tag_busy = '0;    // offered or in flight
    rob_tag_t           next_tag = '0;    // wraps modulo ROB_LEN
    int                 pending, value_errs, proto_errs, lost_errs;

    always #4 clock = ~clock;

    exec_stage dut0 (.*);

    exec_checker chk0 (
        .clock, .reset, .clear_i, .issue_valid_i, .issue_unit_i, .issue_func_i,
        .issue_tag_i, .issue_opa_i, .issue_opb_i, .issue_npc_i, .issue_halt_i,
        .issue_ready_i (issue_ready_o),
        .cdb_valid_i   (cdb_valid_o),
        .cdb_tag_i     (cdb_tag_o),
        .cdb_value_i   (cdb_value_o),
        .cdb_npc_i     (cdb_npc_o),
        .cdb_halt_i    (cdb_halt_o),
        .done_i        (run_done),
        .pending_o     (pending),
        .value_errs_o  (value_errs),
        .proto_errs_o  (proto_errs),
        .lost_errs_o   (lost_errs)
    );

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // corner values now and then
    function automatic word_t pick_operand();
        logic [31:0] r;
        r = rand_next();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            default: return rand_next();
        endcase
    endfunction

    always @(posedge clock) begin : drive
        logic [NUM_LANES-1:0] fire;
        logic [31:0]          r;
        logic [31:0]          f;
        logic                 offer;
        fire = issue_valid_i & issue_ready_o & {NUM_LANES{~clear_i}};
        for (int p = 0; p < CDB_WIDTH; p++)
            if (cdb_valid_o[p]) tag_busy[cdb_tag_o[p]] = 1'b0;
        if (clear_i) begin
            tag_busy = '0;                // only held offers survive a squash
            for (int l = 0; l < NUM_LANES; l++)
                if (issue_valid_i[l]) tag_busy[issue_tag_i[l]] = 1'b1;
        end
        r = rand_next();
        clear_i <= (phase == 1) && (r[6:0] == 7'd0);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (!issue_valid_i[l] || fire[l]) begin   // lane free for a new op
                r = rand_next();
                offer = (phase == 1) ? (r[3:0] < 4'd7) : (phase == 2) && (r[3:0] != 4'd0);
                if (offer && !tag_busy[next_tag]) begin
                    f = rand_next() % 6;
                    issue_valid_i[l] <= 1'b1;
                    issue_unit_i[l]  <= fu_kind_e'(r[4]);
                    issue_func_i[l]  <= alu_func_e'(f[2:0]);
                    issue_tag_i[l]   <= next_tag;
                    issue_opa_i[l]   <= pick_operand();
                    issue_opb_i[l]   <= pick_operand();
                    issue_npc_i[l]   <= rand_next() & 32'hffff_fffc;
                    issue_halt_i[l]  <= (r[12:8] == 5'd0);
                    tag_busy[next_tag] = 1'b1;
                    next_tag = next_tag + 1'b1;
                end else begin
                    issue_valid_i[l] <= 1'b0;
                end
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        phase = 1;
        repeat (RAND_CYCLES) @(negedge clock);
        phase = 2;
        repeat (PRESS_CYCLES) @(negedge clock);
        phase = 3;
        // held offers finish, then the checker empties
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            if (issue_valid_i == '0 && pending == 0) break;
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
        run_done <= 1'b1;
        repeat (2) @(posedge clock);
        $display("errors: %0d value, %0d protocol, %0d lost",
                 value_errs, proto_errs, lost_errs);
        if (value_errs + proto_errs + lost_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: sources.f
exec_pkg.sv
fu_if.sv
issue_router.sv
fu_alu.sv
fu_mult.sv
complete_buffer.sv
exec_stage.sv
exec_checker.sv
tb_exec.sv

// File: Makefile
SRCS = exec_pkg.sv fu_if.sv issue_router.sv fu_alu.sv fu_mult.sv \
       complete_buffer.sv exec_stage.sv exec_checker.sv tb_exec.sv

obj_dir/Vtb_exec: sources.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_exec -f sources.f

run: obj_dir/Vtb_exec
	./obj_dir/Vtb_exec | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
